//--- logic/axi_sys_pkg.sv
// Shared definitions for the AXI to system bus bridge
// - AXI and system bus field widths
// - AXI response and burst type codes
// - per beat address step and the bus acknowledge timeout
package axi_sys_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned addr_w = 32;  // AXI and system bus address
  localparam int unsigned data_w = 32;  // one word per beat
  localparam int unsigned sel_w  = 4;   // byte select, one bit per byte
  localparam int unsigned id_w   = 12;  // GP port ID width
  localparam int unsigned len_w  = 4;   // burst length field, up to 16 beats

  // ------------------------------
  // AXI codes
  // ------------------------------
  localparam logic [1:0] resp_okay   = 2'b00;  // normal access done
  localparam logic [1:0] resp_slverr = 2'b10;  // bus error or timeout

  localparam logic [1:0] burst_fixed = 2'b00;  // same address every beat
  localparam logic [1:0] burst_incr  = 2'b01;  // address advances per beat

  // byte increment between beats of an INCR burst
  localparam logic [addr_w-1:0] addr_step = 32'd4;

  // ------------------------------
  // bus acknowledge timeout
  // ------------------------------
  localparam int unsigned timeout_cnt_w = 6;  // wide enough for ack_timeout

  // cycles after the enable pulse before the access is ended with an error
  localparam logic [timeout_cnt_w-1:0] ack_timeout = 6'd32;

endpackage

//--- logic/axi_wr_engine.sv
`timescale 1ns/1ps
// AXI write channel engine
// - AW capture, W beat capture and B response
// - one four-phase bus write request per beat
// - INCR or FIXED addressing, beats counted against awlen
module axi_wr_engine (
  input  logic                            axi0_clk_i,  // bridge clock
  input  logic                            arst_n_i,    // async reset, active low
  // write address channel
  input  logic [axi_sys_pkg::id_w-1:0]    awid_i,
  input  logic [axi_sys_pkg::addr_w-1:0]  awaddr_i,
  input  logic [axi_sys_pkg::len_w-1:0]   awlen_i,     // beats minus one
  input  logic [1:0]                      awburst_i,
  input  logic                            awvalid_i,
  output logic                            awready_o,
  // write data channel
  input  logic [axi_sys_pkg::data_w-1:0]  wdata_i,
  input  logic [axi_sys_pkg::sel_w-1:0]   wstrb_i,
  input  logic                            wlast_i,     // beat count is used instead
  input  logic                            wvalid_i,
  output logic                            wready_o,
  // write response channel
  output logic [axi_sys_pkg::id_w-1:0]    bid_o,
  output logic [1:0]                      bresp_o,
  output logic                            bvalid_o,
  input  logic                            bready_i,
  // request toward the bus sequencer
  output logic                            wr_req_o,
  output logic [axi_sys_pkg::addr_w-1:0]  wr_addr_o,
  output logic [axi_sys_pkg::data_w-1:0]  wr_data_o,
  output logic [axi_sys_pkg::sel_w-1:0]   wr_sel_o,
  input  logic                            wr_ack_i,
  input  logic                            wr_err_i
);

  typedef enum logic [1:0] {
    st_idle,  // waiting for AW
    st_data,  // waiting for a W beat
    st_req,   // bus write in flight
    st_resp   // B response pending
  } state_t;

  state_t                        state;
  logic [axi_sys_pkg::len_w-1:0] len_q;     // awlen of current burst
  logic [axi_sys_pkg::len_w-1:0] beat_cnt;  // beats already written
  logic                          incr_q;    // address advances per beat
  logic                          err_q;     // sticky, any beat erred
  logic                          last_beat;
  logic                          aw_hs;
  logic                          w_hs;

  // ------------------------------
  // handshakes
  // ------------------------------
  // no new beat while the previous ack is still high
  assign wready_o  = (state == st_data) && !wr_ack_i;
  assign aw_hs     = awready_o && awvalid_i;
  assign w_hs      = wready_o && wvalid_i;
  assign last_beat = (beat_cnt == len_q);

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge axi0_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state     <= st_idle;
      awready_o <= 1'b0;
      bvalid_o  <= 1'b0;
      wr_req_o  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          awready_o <= 1'b1;                 // open one cycle after entry
          if (aw_hs) begin
            awready_o <= 1'b0;
            state     <= st_data;
          end
        end
        st_data: begin
          if (w_hs) begin
            wr_req_o <= 1'b1;                // data and address now stable
            state    <= st_req;
          end
        end
        st_req: begin
          if (wr_ack_i) begin
            wr_req_o <= 1'b0;                // phase 3 of the handshake
            if (last_beat) begin
              bvalid_o <= 1'b1;
              state    <= st_resp;
            end else begin
              state <= st_data;
            end
          end
        end
        st_resp: begin
          if (bready_i) begin                // hold bid and bresp until taken
            bvalid_o <= 1'b0;
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------
  // burst and beat payload
  // ------------------------------
  always_ff @(posedge axi0_clk_i) begin
    if (aw_hs) begin
      bid_o     <= awid_i;
      wr_addr_o <= awaddr_i;
      len_q     <= awlen_i;
      incr_q    <= (awburst_i == axi_sys_pkg::burst_incr);
      beat_cnt  <= '0;
      err_q     <= 1'b0;
    end
    if (w_hs) begin
      wr_data_o <= wdata_i;
      wr_sel_o  <= wstrb_i;
    end
    if ((state == st_req) && wr_ack_i) begin
      err_q    <= err_q | wr_err_i;
      beat_cnt <= beat_cnt + 1'b1;
      if (incr_q)
        wr_addr_o <= wr_addr_o + axi_sys_pkg::addr_step;  // next word
      if (last_beat)
        bresp_o <= (err_q | wr_err_i) ? axi_sys_pkg::resp_slverr : axi_sys_pkg::resp_okay;
    end
  end

endmodule

//--- logic/axi_rd_engine.sv
`timescale 1ns/1ps
// AXI read channel engine
// - AR capture and per beat four-phase bus read request
// - R beat built from returned data and error, held under rready stalls
// - INCR or FIXED addressing, rlast on beat arlen
module axi_rd_engine (
  input  logic                            axi0_clk_i,  // bridge clock
  input  logic                            arst_n_i,    // async reset, active low
  // read address channel
  input  logic [axi_sys_pkg::id_w-1:0]    arid_i,
  input  logic [axi_sys_pkg::addr_w-1:0]  araddr_i,
  input  logic [axi_sys_pkg::len_w-1:0]   arlen_i,     // beats minus one
  input  logic [1:0]                      arburst_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,
  // read data channel
  output logic [axi_sys_pkg::id_w-1:0]    rid_o,
  output logic [axi_sys_pkg::data_w-1:0]  rdata_o,
  output logic [1:0]                      rresp_o,     // per beat response
  output logic                            rlast_o,
  output logic                            rvalid_o,
  input  logic                            rready_i,
  // request toward the bus sequencer
  output logic                            rd_req_o,
  output logic [axi_sys_pkg::addr_w-1:0]  rd_addr_o,
  input  logic                            rd_ack_i,
  input  logic                            rd_err_i,
  input  logic [axi_sys_pkg::data_w-1:0]  rd_data_i
);

  typedef enum logic [1:0] {
    st_idle,   // waiting for AR
    st_issue,  // raise request once previous ack is gone
    st_wait,   // bus read in flight
    st_resp    // R beat pending
  } state_t;

  state_t                        state;
  logic [axi_sys_pkg::len_w-1:0] len_q;     // arlen of current burst
  logic [axi_sys_pkg::len_w-1:0] beat_cnt;  // beat being read
  logic                          incr_q;
  logic                          ar_hs;
  logic                          r_hs;

  assign ar_hs = arready_o && arvalid_i;
  assign r_hs  = rvalid_o && rready_i;

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge axi0_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state     <= st_idle;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rd_req_o  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          arready_o <= 1'b1;
          if (ar_hs) begin
            arready_o <= 1'b0;
            state     <= st_issue;
          end
        end
        st_issue: begin
          if (!rd_ack_i) begin               // four-phase, ack must be low first
            rd_req_o <= 1'b1;
            state    <= st_wait;
          end
        end
        st_wait: begin
          if (rd_ack_i) begin
            rd_req_o <= 1'b0;
            rvalid_o <= 1'b1;                // R beat in the cycle after ack
            state    <= st_resp;
          end
        end
        st_resp: begin
          if (rready_i) begin                // no new bus read while stalled
            rvalid_o <= 1'b0;
            state    <= rlast_o ? st_idle : st_issue;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------
  // burst and beat payload
  // ------------------------------
  always_ff @(posedge axi0_clk_i) begin
    if (ar_hs) begin
      rid_o     <= arid_i;
      rd_addr_o <= araddr_i;
      len_q     <= arlen_i;
      incr_q    <= (arburst_i == axi_sys_pkg::burst_incr);
      beat_cnt  <= '0;
    end
    if ((state == st_wait) && rd_ack_i) begin
      rdata_o <= rd_data_i;
      rresp_o <= rd_err_i ? axi_sys_pkg::resp_slverr : axi_sys_pkg::resp_okay;
      rlast_o <= (beat_cnt == len_q);
    end
    if (r_hs) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (incr_q)
        rd_addr_o <= rd_addr_o + axi_sys_pkg::addr_step;
    end
  end

endmodule

//--- logic/sys_bus_sequencer.sv
`timescale 1ns/1ps
// System bus sequencer
// - round-robin grant between read and write engine requests
// - one enable pulse per access, acknowledge timeout
// - four-phase ack back to the granted engine
module sys_bus_sequencer (
  input  logic                            axi0_clk_i,  // bridge clock
  input  logic                            arst_n_i,    // async reset, active low
  // write engine side
  input  logic                            wr_req_i,
  input  logic [axi_sys_pkg::addr_w-1:0]  wr_addr_i,
  input  logic [axi_sys_pkg::data_w-1:0]  wr_data_i,
  input  logic [axi_sys_pkg::sel_w-1:0]   wr_sel_i,
  output logic                            wr_ack_o,
  output logic                            wr_err_o,
  // read engine side
  input  logic                            rd_req_i,
  input  logic [axi_sys_pkg::addr_w-1:0]  rd_addr_i,
  output logic                            rd_ack_o,
  output logic                            rd_err_o,
  output logic [axi_sys_pkg::data_w-1:0]  rd_data_o,
  // system bus
  output logic [axi_sys_pkg::addr_w-1:0]  sys_addr_o,
  output logic [axi_sys_pkg::data_w-1:0]  sys_wdata_o,
  output logic [axi_sys_pkg::sel_w-1:0]   sys_sel_o,
  output logic                            sys_wen_o,   // one cycle pulse
  output logic                            sys_rd_en_o, // one cycle pulse
  input  logic [axi_sys_pkg::data_w-1:0]  sys_rdata_i,
  input  logic                            sys_err_i,
  input  logic                            sys_ack_i
);

  typedef enum logic [1:0] {st_idle, st_bus, st_done} state_t;

  state_t                                state;
  logic                                  prio_rd;   // read wins a tie
  logic                                  owner_wr;  // access belongs to write engine
  logic [axi_sys_pkg::timeout_cnt_w-1:0] timer;     // cycles since enable pulse
  logic                                  err_q;
  logic                                  grant_rd;
  logic                                  grant_wr;
  logic                                  bus_end;

  assign grant_rd = rd_req_i && (!wr_req_i || prio_rd);
  assign grant_wr = wr_req_i && !grant_rd;
  assign bus_end  = sys_ack_i || (timer == axi_sys_pkg::ack_timeout);
  assign wr_err_o = err_q;   // only the owner's ack qualifies it
  assign rd_err_o = err_q;

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge axi0_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state       <= st_idle;
      prio_rd     <= 1'b0;
      owner_wr    <= 1'b0;
      timer       <= '0;
      sys_wen_o   <= 1'b0;
      sys_rd_en_o <= 1'b0;
      wr_ack_o    <= 1'b0;
      rd_ack_o    <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          timer <= '0;
          if (grant_rd || grant_wr) begin
            owner_wr    <= grant_wr;
            sys_wen_o   <= grant_wr;         // pulse in the cycle after grant
            sys_rd_en_o <= grant_rd;
            prio_rd     <= grant_wr;         // other side next time
            state       <= st_bus;
          end
        end
        st_bus: begin
          sys_wen_o   <= 1'b0;
          sys_rd_en_o <= 1'b0;
          timer       <= timer + 1'b1;
          if (bus_end) begin
            wr_ack_o <= owner_wr;
            rd_ack_o <= !owner_wr;
            state    <= st_done;
          end
        end
        st_done: begin
          if (owner_wr ? !wr_req_i : !rd_req_i) begin  // req seen low
            wr_ack_o <= 1'b0;
            rd_ack_o <= 1'b0;
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------
  // bus payload and result
  // ------------------------------
  always_ff @(posedge axi0_clk_i) begin
    if ((state == st_idle) && (grant_rd || grant_wr)) begin
      sys_addr_o  <= grant_wr ? wr_addr_i : rd_addr_i;
      sys_wdata_o <= wr_data_i;
      sys_sel_o   <= grant_wr ? wr_sel_i : '1;          // reads take the whole word
    end
    if ((state == st_bus) && bus_end) begin
      err_q     <= !sys_ack_i || sys_err_i;             // timeout counts as error
      rd_data_o <= sys_ack_i ? sys_rdata_i : '0;
    end
  end

endmodule

//--- logic/axi_sys_bridge.sv
`timescale 1ns/1ps
// AXI slave to system bus bridge, top level
// - write engine, read engine and shared bus sequencer
module axi_sys_bridge (
  input  logic                            axi0_clk_i,
  input  logic                            arst_n_i,
  // write address
  input  logic [axi_sys_pkg::id_w-1:0]    awid_i,
  input  logic [axi_sys_pkg::addr_w-1:0]  awaddr_i,
  input  logic [axi_sys_pkg::len_w-1:0]   awlen_i,
  input  logic [1:0]                      awburst_i,
  input  logic                            awvalid_i,
  output logic                            awready_o,
  // write data
  input  logic [axi_sys_pkg::data_w-1:0]  wdata_i,
  input  logic [axi_sys_pkg::sel_w-1:0]   wstrb_i,
  input  logic                            wlast_i,
  input  logic                            wvalid_i,
  output logic                            wready_o,
  // write response
  output logic [axi_sys_pkg::id_w-1:0]    bid_o,
  output logic [1:0]                      bresp_o,
  output logic                            bvalid_o,
  input  logic                            bready_i,
  // read address
  input  logic [axi_sys_pkg::id_w-1:0]    arid_i,
  input  logic [axi_sys_pkg::addr_w-1:0]  araddr_i,
  input  logic [axi_sys_pkg::len_w-1:0]   arlen_i,
  input  logic [1:0]                      arburst_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,
  // read data
  output logic [axi_sys_pkg::id_w-1:0]    rid_o,
  output logic [axi_sys_pkg::data_w-1:0]  rdata_o,
  output logic [1:0]                      rresp_o,
  output logic                            rlast_o,
  output logic                            rvalid_o,
  input  logic                            rready_i,
  // system bus
  output logic [axi_sys_pkg::addr_w-1:0]  sys_addr_o,
  output logic [axi_sys_pkg::data_w-1:0]  sys_wdata_o,
  output logic [axi_sys_pkg::sel_w-1:0]   sys_sel_o,
  output logic                            sys_wen_o,
  output logic                            sys_rd_en_o,
  input  logic [axi_sys_pkg::data_w-1:0]  sys_rdata_i,
  input  logic                            sys_err_i,
  input  logic                            sys_ack_i
);

  // ------------------------------
  // engine to sequencer handshake
  // ------------------------------
  logic                           wr_req, wr_ack, wr_err;
  logic [axi_sys_pkg::addr_w-1:0] wr_addr;
  logic [axi_sys_pkg::data_w-1:0] wr_data;
  logic [axi_sys_pkg::sel_w-1:0]  wr_sel;
  logic                           rd_req, rd_ack, rd_err;
  logic [axi_sys_pkg::addr_w-1:0] rd_addr;
  logic [axi_sys_pkg::data_w-1:0] rd_data;

  // AXI ports connect by name, internal ones listed
  axi_wr_engine u_wr (
    .*,
    .wr_req_o  (wr_req),
    .wr_addr_o (wr_addr),
    .wr_data_o (wr_data),
    .wr_sel_o  (wr_sel),
    .wr_ack_i  (wr_ack),
    .wr_err_i  (wr_err)
  );

  axi_rd_engine u_rd (
    .*,
    .rd_req_o  (rd_req),
    .rd_addr_o (rd_addr),
    .rd_ack_i  (rd_ack),
    .rd_err_i  (rd_err),
    .rd_data_i (rd_data)
  );

  sys_bus_sequencer u_seq (
    .*,
    .wr_req_i  (wr_req),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .wr_sel_i  (wr_sel),
    .wr_ack_o  (wr_ack),
    .wr_err_o  (wr_err),
    .rd_req_i  (rd_req),
    .rd_addr_i (rd_addr),
    .rd_ack_o  (rd_ack),
    .rd_err_o  (rd_err),
    .rd_data_o (rd_data)
  );

endmodule

//--- verification/sys_mem_model.sv
`timescale 1ns/1ps
// System bus slave memory for the bridge testbench
// - 256 words indexed by address bits 9:2, byte select writes
// - random ack latency of 1 to 6 cycles
// - error region 0xF and silent region 0xE in address bits 15:12
module sys_mem_model #(
  parameter int seed_init = 1
) (
  input  logic                            axi0_clk_i,
  input  logic                            arst_n_i,
  input  logic [axi_sys_pkg::addr_w-1:0]  sys_addr_i,
  input  logic [axi_sys_pkg::data_w-1:0]  sys_wdata_i,
  input  logic [axi_sys_pkg::sel_w-1:0]   sys_sel_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_rd_en_i,
  output logic [axi_sys_pkg::data_w-1:0]  sys_rdata_o,
  output logic                            sys_err_o,
  output logic                            sys_ack_o
);

  logic [31:0] mem [256];
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  sel_q;
  logic        wen_q;
  logic        busy;
  logic [2:0]  wait_cnt;    // extra cycles before ack
  integer      seed;

  initial begin
    seed = seed_init;
    for (int i = 0; i < 256; i++)
      mem[i] = {8'ha5, 8'(i), ~8'(i), 8'(i) ^ 8'h3c};  // pattern over the full index
  end

  always @(posedge axi0_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy        <= 1'b0;
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o <= 1'b0;                     // ack is a single cycle
      sys_err_o <= 1'b0;
      if ((sys_wen_i || sys_rd_en_i) && (sys_addr_i[15:12] != 4'he)) begin
        busy     <= 1'b1;                    // silent region never answers
        wait_cnt <= 3'({$random(seed)} % 6);
        addr_q   <= sys_addr_i;
        wdata_q  <= sys_wdata_i;
        sel_q    <= sys_sel_i;
        wen_q    <= sys_wen_i;
      end else if (busy) begin
        if (wait_cnt != 3'd0) begin
          wait_cnt <= wait_cnt - 3'd1;
        end else begin
          busy      <= 1'b0;
          sys_ack_o <= 1'b1;
          if (addr_q[15:12] == 4'hf) begin   // error region, no access
            sys_err_o   <= 1'b1;
            sys_rdata_o <= '0;
          end else begin
            sys_rdata_o <= mem[addr_q[9:2]];
            for (int i = 0; i < 4; i++)
              if (wen_q && sel_q[i]) mem[addr_q[9:2]][8*i +: 8] <= wdata_q[8*i +: 8];
          end
        end
      end
    end
  end

endmodule

//--- verification/axi_sys_bridge_tb.sv
`timescale 1ns/1ps
// Testbench for the AXI to system bus bridge
// - AXI master tasks with random W gaps and random B and R stalls
// - word mirror of the bus memory for expected data and responses
// - round trip, INCR, FIXED, error region and timeout tests, watchdog
module axi_sys_bridge_tb;

  localparam int  seed_val    = 47147;
  localparam time clk_period  = 100;
  localparam int  n_txn       = 48;                             // bound on transactions
  localparam int  beat_cycles = axi_sys_pkg::ack_timeout + 16;  // worst case per beat

  logic                           axi0_clk_i, arst_n_i;
  logic [axi_sys_pkg::id_w-1:0]   awid_i, arid_i, bid_o, rid_o;
  logic [axi_sys_pkg::addr_w-1:0] awaddr_i, araddr_i, sys_addr_o;
  logic [axi_sys_pkg::data_w-1:0] wdata_i, rdata_o, sys_wdata_o, sys_rdata_i;
  logic [axi_sys_pkg::len_w-1:0]  awlen_i, arlen_i;
  logic [axi_sys_pkg::sel_w-1:0]  wstrb_i, sys_sel_o;
  logic [1:0]                     awburst_i, arburst_i, bresp_o, rresp_o;
  logic                           awvalid_i, awready_o, wlast_i, wvalid_i, wready_o;
  logic                           bvalid_o, bready_i, arvalid_i, arready_o;
  logic                           rlast_o, rvalid_o, rready_i;
  logic                           sys_wen_o, sys_rd_en_o, sys_err_i, sys_ack_i;

  integer      seed;
  logic [31:0] model [256];     // mirror of the bus memory
  logic [31:0] addrs [$];
  logic [31:0] a;
  int          len;
  int          k;
  logic        en_q;            // bus enable seen one cycle earlier

  axi_sys_bridge u_dut (.*);

  sys_mem_model #(.seed_init(seed_val)) u_mem (
    .axi0_clk_i  (axi0_clk_i),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_o),
    .sys_wdata_i (sys_wdata_o),
    .sys_sel_i   (sys_sel_o),
    .sys_wen_i   (sys_wen_o),
    .sys_rd_en_i (sys_rd_en_o),
    .sys_rdata_o (sys_rdata_i),
    .sys_err_o   (sys_err_i),
    .sys_ack_o   (sys_ack_i)
  );

  initial begin
    axi0_clk_i = 1'b0;
    forever #(clk_period / 2) axi0_clk_i = ~axi0_clk_i;
  end

  initial begin
    #(n_txn * 16 * beat_cycles * clk_period);
    $display("TIMEOUT: bridge did not finish all transactions in time");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  // initial word contents from the word index
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {8'ha5, idx, ~idx, idx ^ 8'h3c};
  endfunction

  task automatic check(input string name, input logic [31:0] exp_val, input logic [31:0] act_val);
    assert (exp_val === act_val) else begin
      $display("ERROR %s: expected %h actual %h", name, exp_val, act_val);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one cycle bus enable pulses and whole word read select
  always @(negedge axi0_clk_i) begin
    if (arst_n_i) begin
      if (sys_wen_o || sys_rd_en_o) begin
        check("bus enable pulse", 0, en_q);
        check("bus enables both high", 0, sys_wen_o && sys_rd_en_o);
      end
      if (sys_rd_en_o)
        check("bus read select", 4'hf, sys_sel_o);
    end
    en_q = sys_wen_o || sys_rd_en_o;
  end

  task automatic write_burst(input string name, input logic [31:0] addr, input int blen,
                             input logic [1:0] burst);
    logic [axi_sys_pkg::id_w-1:0] id;
    logic [31:0]                  wa;
    logic                         err;
    logic                         got;
    int                           b;
    id  = 12'($random(seed));
    wa  = addr;
    err = 1'b0;
    got = 1'b0;
    @(negedge axi0_clk_i);
    {awid_i, awaddr_i, awlen_i, awburst_i} = {id, addr, 4'(blen), burst};
    awvalid_i = 1'b1;
    while (!awready_o) @(negedge axi0_clk_i);  // taken at the next rising edge
    @(negedge axi0_clk_i);
    awvalid_i = 1'b0;
    for (b = 0; b <= blen; b++) begin
      repeat ({$random(seed)} % 3) @(negedge axi0_clk_i);  // idle gap on W
      wdata_i  = $random(seed);
      wstrb_i  = 4'($random(seed));
      wlast_i  = (b == blen);
      wvalid_i = 1'b1;
      while (!wready_o) @(negedge axi0_clk_i);
      @(negedge axi0_clk_i);
      wvalid_i = 1'b0;
      if (wa[15:13] == 3'b111)               // E and F regions leave memory untouched
        err = 1'b1;
      else
        for (int i = 0; i < 4; i++)
          if (wstrb_i[i]) model[wa[9:2]][8*i +: 8] = wdata_i[8*i +: 8];
      if (burst == axi_sys_pkg::burst_incr) wa = wa + 32'd4;
    end
    while (!got) begin
      @(negedge axi0_clk_i);
      bready_i = 1'b0;
      if (bvalid_o) begin                    // checked every stalled cycle too
        check({name, " bid"}, id, bid_o);
        check({name, " bresp"}, err ? axi_sys_pkg::resp_slverr : axi_sys_pkg::resp_okay, bresp_o);
        check({name, " awready during B"}, 0, awready_o);
        bready_i = ({$random(seed)} % 4) != 0;
        got      = bready_i;
      end
    end
    @(negedge axi0_clk_i);
    bready_i = 1'b0;
    check({name, " bvalid after accept"}, 0, bvalid_o);  // no duplicate response
  endtask

  task automatic read_burst(input string name, input logic [31:0] addr, input int blen,
                            input logic [1:0] burst);
    logic [axi_sys_pkg::id_w-1:0] id;
    logic [31:0]                  ra;
    logic                         bad;
    int                           b;
    id = 12'($random(seed));
    ra = addr;
    b  = 0;
    @(negedge axi0_clk_i);
    {arid_i, araddr_i, arlen_i, arburst_i} = {id, addr, 4'(blen), burst};
    arvalid_i = 1'b1;
    while (!arready_o) @(negedge axi0_clk_i);
    @(negedge axi0_clk_i);
    arvalid_i = 1'b0;
    while (b <= blen) begin
      @(negedge axi0_clk_i);
      rready_i = 1'b0;
      if (rvalid_o) begin
        bad = (ra[15:13] == 3'b111);         // error or silent region
        check({name, " rid"}, id, rid_o);
        check({name, " rdata"}, bad ? 32'h0 : model[ra[9:2]], rdata_o);
        check({name, " rresp"}, bad ? axi_sys_pkg::resp_slverr : axi_sys_pkg::resp_okay, rresp_o);
        check({name, " rlast"}, b == blen, rlast_o);
        rready_i = ({$random(seed)} % 4) != 0;
        if (rready_i) begin
          b = b + 1;
          if (burst == axi_sys_pkg::burst_incr) ra = ra + 32'd4;
        end
      end
    end
    @(negedge axi0_clk_i);
    rready_i = 1'b0;
    check({name, " rvalid after last"}, 0, rvalid_o);
  endtask

  initial begin
    seed = seed_val;
    {awvalid_i, wvalid_i, wlast_i, bready_i, arvalid_i, rready_i} = '0;
    {awid_i, awaddr_i, awlen_i, awburst_i} = '0;
    {arid_i, araddr_i, arlen_i, arburst_i} = '0;
    {wdata_i, wstrb_i} = '0;
    arst_n_i = 1'b0;
    for (k = 0; k < 256; k++) model[k] = fill_word(8'(k));
    repeat (3) @(negedge axi0_clk_i);
    arst_n_i = 1'b1;
    // ------------------------------
    for (k = 0; k < 8; k++) begin            // round trip of single beats
      a = {22'h0, 8'($random(seed)), 2'b00};
      addrs.push_back(a);
      write_burst("round trip", a, 0, axi_sys_pkg::burst_incr);
    end
    foreach (addrs[j]) read_burst("round trip", addrs[j], 0, axi_sys_pkg::burst_incr);
    len = {$random(seed)} % 16;              // INCR burst read back two ways
    a   = {22'h0, 8'($random(seed)), 2'b00};
    write_burst("incr burst", a, len, axi_sys_pkg::burst_incr);
    read_burst("incr burst", a, len, axi_sys_pkg::burst_incr);
    for (k = 0; k <= len; k++) read_burst("incr single", a + 4 * k, 0, axi_sys_pkg::burst_incr);
    len = 1 + {$random(seed)} % 15;          // FIXED burst merges into one word
    a   = {22'h0, 8'($random(seed)), 2'b00};
    write_burst("fixed burst", a, len, axi_sys_pkg::burst_fixed);
    read_burst("fixed burst", a, 0, axi_sys_pkg::burst_fixed);
    // ------------------------------
    write_burst("error single", 32'h0000_f120, 0, axi_sys_pkg::burst_incr);
    read_burst("error single", 32'h0000_f120, 0, axi_sys_pkg::burst_incr);
    write_burst("error burst", 32'h0000_fffc, 2, axi_sys_pkg::burst_incr);  // first beat errs
    read_burst("error burst", 32'h0000_fffc, 2, axi_sys_pkg::burst_incr);
    write_burst("timeout", 32'h0000_e040, 0, axi_sys_pkg::burst_incr);
    read_burst("timeout", 32'h0000_e040, 1, axi_sys_pkg::burst_incr);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- build.f
logic/axi_sys_pkg.sv
logic/axi_wr_engine.sv
logic/axi_rd_engine.sv
logic/sys_bus_sequencer.sv
logic/axi_sys_bridge.sv
verification/sys_mem_model.sv
verification/axi_sys_bridge_tb.sv

//--- Bender.yml
package:
  name: axi_sys_bridge

sources:
  # RTL in compile order
  - logic/axi_sys_pkg.sv
  - logic/axi_wr_engine.sv
  - logic/axi_rd_engine.sv
  - logic/sys_bus_sequencer.sv
  - logic/axi_sys_bridge.sv
  # simulation only
  - target: test
    files:
      - verification/sys_mem_model.sv
      - verification/axi_sys_bridge_tb.sv
